// ==== issueStage.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "tomasulo_defs.svh"

module issueStage (
    input logic clk,
    input logic reset,
    input tomasulo_pkg::regAddr_t rs,
    input tomasulo_pkg::regAddr_t rt,
    input tomasulo_pkg::regAddr_t rd,
    input logic addEn,
    input logic mulEn,
    input logic opSel,
    input logic immInstr,
    input tomasulo_pkg::word_t extImm,
    input tomasulo_pkg::word_t readData1,
    input tomasulo_pkg::word_t readData2,
    input tomasulo_pkg::cdb_t cdb,
    input logic [`ADD_N-1:0] addFree,
    input logic [`MUL_N-1:0] mulFree,
    output logic stall,
    output logic [`ADD_N-1:0] addAlloc,
    output logic [`MUL_N-1:0] mulAlloc,
    output tomasulo_pkg::newEntry_t entry,
    output tomasulo_pkg::regWrite_t regWrite,
    output tomasulo_pkg::regAddr_t readAddr1,
    output tomasulo_pkg::regAddr_t readAddr2
);

    tomasulo_pkg::tag_t regStat [`REG_N];
    logic [`REG_N-1:0] statHit;
    logic [`ADD_N-1:0] addPick;
    logic [`MUL_N-1:0] mulPick;
    tomasulo_pkg::tag_t addTag;
    tomasulo_pkg::tag_t mulTag;
    tomasulo_pkg::tag_t newTag;
    logic addGo;
    logic mulGo;
    tomasulo_pkg::regAddr_t hitAddr;
    logic wbValid;
    tomasulo_pkg::regAddr_t wbAddr;
    tomasulo_pkg::word_t wbData;

    // cdb bypass first, then the pending tag, then the register file
    function automatic tomasulo_pkg::operand_t resolve(
        input tomasulo_pkg::tag_t q,
        input tomasulo_pkg::word_t d,
        input tomasulo_pkg::cdb_t c
    );
        tomasulo_pkg::operand_t o;
        o.q = q;
        o.v = d;
        if (q != '0 && c.valid && c.tag == q) begin
            o.q = '0;
            o.v = c.data;
        end
        return o;
    endfunction

    assign readAddr1 = rs;
    assign readAddr2 = rt;

    // lowest free station of each class
    always_comb begin
        addPick = '0;
        addTag = '0;
        for (int i = `ADD_N - 1; i >= 0; i--) begin
            if (addFree[i]) begin
                addPick = '0;
                addPick[i] = 1'b1;
                addTag = tomasulo_pkg::tag_t'(`ADD_BASE + i);
            end
        end
    end

    always_comb begin
        mulPick = '0;
        mulTag = '0;
        for (int i = `MUL_N - 1; i >= 0; i--) begin
            if (mulFree[i]) begin
                mulPick = '0;
                mulPick[i] = 1'b1;
                mulTag = tomasulo_pkg::tag_t'(`MUL_BASE + i);
            end
        end
    end

    // add wins when both enables are up
    assign addGo = addEn && (|addFree);
    assign mulGo = !addEn && mulEn && (|mulFree);
    assign stall = (addEn && !(|addFree)) || (!addEn && mulEn && !(|mulFree));
    assign addAlloc = addGo ? addPick : '0;
    assign mulAlloc = mulGo ? mulPick : '0;
    assign newTag = addEn ? addTag : mulTag;

    always_comb begin
        entry.j = resolve(regStat[rs], readData1, cdb);
        if (immInstr) begin
            entry.k.q = '0;
            entry.k.v = extImm;
        end else begin
            entry.k = resolve(regStat[rt], readData2, cdb);
        end
        entry.op = opSel;
    end

    // registers waiting on the broadcast tag
    always_comb begin
        statHit = '0;
        hitAddr = '0;
        for (int i = 0; i < `REG_N; i++) begin
            if (cdb.valid && cdb.tag != '0 && regStat[i] == cdb.tag) begin
                statHit[i] = 1'b1;
                hitAddr = tomasulo_pkg::regAddr_t'(i);
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < `REG_N; i++) begin
                regStat[i] <= '0;
            end
            wbValid <= 1'b0;
        end else begin
            for (int i = 0; i < `REG_N; i++) begin
                if (statHit[i]) begin
                    regStat[i] <= '0;
                end
            end
            // a rename on the same edge overrides the clear
            if (addGo || mulGo) begin
                regStat[rd] <= newTag;
            end
            wbValid <= |statHit;
        end
    end

    always_ff @(posedge clk) begin
        if (|statHit) begin
            wbAddr <= hitAddr;
            wbData <= cdb.data;
        end
    end

    assign regWrite = '{valid: wbValid, addr: wbAddr, data: wbData};

endmodule

`default_nettype wire

// ==== launchStage.sv ====
`timescale 1ns/1ns
`default_nettype none

module launchStage #(
    parameter type opT = logic,
    parameter int depth = 2
) (
    input logic clk,
    input logic reset,
    input logic [depth-1:0] ready,
    input tomasulo_pkg::word_t srcA [depth],
    input tomasulo_pkg::word_t srcB [depth],
    input opT ops [depth],
    input tomasulo_pkg::tag_t tags [depth],
    output logic [depth-1:0] fire,
    output tomasulo_pkg::launch_t launch
);

    tomasulo_pkg::word_t pickA;
    tomasulo_pkg::word_t pickB;
    tomasulo_pkg::tag_t pickTag;
    opT pickOp;
    logic startQ;
    tomasulo_pkg::word_t aQ;
    tomasulo_pkg::word_t bQ;
    tomasulo_pkg::tag_t tagQ;
    opT opQ;

    // lowest ready index wins
    always_comb begin
        fire = '0;
        for (int i = depth - 1; i >= 0; i--) begin
            if (ready[i]) begin
                fire = '0;
                fire[i] = 1'b1;
            end
        end
    end

    always_comb begin
        pickA = srcA[0];
        pickB = srcB[0];
        pickTag = tags[0];
        pickOp = ops[0];
        for (int i = 1; i < depth; i++) begin
            if (fire[i]) begin
                pickA = srcA[i];
                pickB = srcB[i];
                pickTag = tags[i];
                pickOp = ops[i];
            end
        end
    end

    // one-cycle start pulse
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            startQ <= 1'b0;
        end else begin
            startQ <= |fire;
        end
    end

    always_ff @(posedge clk) begin
        if (|fire) begin
            aQ <= pickA;
            bQ <= pickB;
            tagQ <= pickTag;
            opQ <= pickOp;
        end
    end

    assign launch = '{start: startQ, srcA: aQ, srcB: bQ, tag: tagQ, op: opQ};

endmodule

`default_nettype wire

// ==== reservationStation.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "tomasulo_defs.svh"

module reservationStation (
    input logic clk,
    input logic reset,
    input tomasulo_pkg::regAddr_t rs,
    input tomasulo_pkg::regAddr_t rt,
    input tomasulo_pkg::regAddr_t rd,
    input logic addEn,
    input logic mulEn,
    input logic opSel,
    input logic immInstr,
    input tomasulo_pkg::word_t extImm,
    input tomasulo_pkg::word_t readData1,
    input tomasulo_pkg::word_t readData2,
    input tomasulo_pkg::cdb_t cdb,
    output logic stall,
    output tomasulo_pkg::launch_t addLaunch,
    output tomasulo_pkg::launch_t mulLaunch,
    output tomasulo_pkg::regWrite_t regWrite,
    output tomasulo_pkg::regAddr_t readAddr1,
    output tomasulo_pkg::regAddr_t readAddr2
);

    tomasulo_pkg::newEntry_t entry;
    logic [`ADD_N-1:0] addAlloc;
    logic [`ADD_N-1:0] addFree;
    logic [`ADD_N-1:0] addReady;
    logic [`ADD_N-1:0] addFire;
    tomasulo_pkg::word_t addSrcA [`ADD_N];
    tomasulo_pkg::word_t addSrcB [`ADD_N];
    tomasulo_pkg::addOp_t addOps [`ADD_N];
    tomasulo_pkg::tag_t addTags [`ADD_N];
    logic [`MUL_N-1:0] mulAlloc;
    logic [`MUL_N-1:0] mulFree;
    logic [`MUL_N-1:0] mulReady;
    logic [`MUL_N-1:0] mulFire;
    tomasulo_pkg::word_t mulSrcA [`MUL_N];
    tomasulo_pkg::word_t mulSrcB [`MUL_N];
    tomasulo_pkg::mulOp_t mulOps [`MUL_N];
    tomasulo_pkg::tag_t mulTags [`MUL_N];

    issueStage issue (
        .clk(clk),
        .reset(reset),
        .rs(rs),
        .rt(rt),
        .rd(rd),
        .addEn(addEn),
        .mulEn(mulEn),
        .opSel(opSel),
        .immInstr(immInstr),
        .extImm(extImm),
        .readData1(readData1),
        .readData2(readData2),
        .cdb(cdb),
        .addFree(addFree),
        .mulFree(mulFree),
        .stall(stall),
        .addAlloc(addAlloc),
        .mulAlloc(mulAlloc),
        .entry(entry),
        .regWrite(regWrite),
        .readAddr1(readAddr1),
        .readAddr2(readAddr2)
    );

    stationBank #(.opT(tomasulo_pkg::addOp_t), .depth(`ADD_N)) addBank (
        .clk(clk),
        .reset(reset),
        .alloc(addAlloc),
        .entry(entry),
        .fire(addFire),
        .cdb(cdb),
        .baseTag(tomasulo_pkg::tag_t'(`ADD_BASE)),
        .free(addFree),
        .ready(addReady),
        .srcA(addSrcA),
        .srcB(addSrcB),
        .ops(addOps),
        .tags(addTags)
    );

    stationBank #(.opT(tomasulo_pkg::mulOp_t), .depth(`MUL_N)) mulBank (
        .clk(clk),
        .reset(reset),
        .alloc(mulAlloc),
        .entry(entry),
        .fire(mulFire),
        .cdb(cdb),
        .baseTag(tomasulo_pkg::tag_t'(`MUL_BASE)),
        .free(mulFree),
        .ready(mulReady),
        .srcA(mulSrcA),
        .srcB(mulSrcB),
        .ops(mulOps),
        .tags(mulTags)
    );

    launchStage #(.opT(tomasulo_pkg::addOp_t), .depth(`ADD_N)) addLaunchStage (
        .clk(clk),
        .reset(reset),
        .ready(addReady),
        .srcA(addSrcA),
        .srcB(addSrcB),
        .ops(addOps),
        .tags(addTags),
        .fire(addFire),
        .launch(addLaunch)
    );

    launchStage #(.opT(tomasulo_pkg::mulOp_t), .depth(`MUL_N)) mulLaunchStage (
        .clk(clk),
        .reset(reset),
        .ready(mulReady),
        .srcA(mulSrcA),
        .srcB(mulSrcB),
        .ops(mulOps),
        .tags(mulTags),
        .fire(mulFire),
        .launch(mulLaunch)
    );

endmodule

`default_nettype wire

// ==== rs_asserts.sv ====
`timescale 1ns/1ns
`default_nettype none

module rsAsserts (
    input logic clk,
    input logic reset,
    input logic addEn,
    input logic mulEn,
    input logic stall,
    input tomasulo_pkg::cdb_t cdb,
    input tomasulo_pkg::launch_t addLaunch,
    input tomasulo_pkg::launch_t mulLaunch,
    input tomasulo_pkg::regWrite_t regWrite
);

    int failCount = 0;

    // a launch follows an issue or a broadcast two edges back, or a launch just before
    addStartCause: assert property (@(posedge clk) disable iff (reset)
        addLaunch.start |-> $past(addEn || mulEn || cdb.valid, 2) || $past(addLaunch.start))
    else begin
        $error("adder start without an earlier issue or CDB");
        failCount++;
    end

    mulStartCause: assert property (@(posedge clk) disable iff (reset)
        mulLaunch.start |-> $past(addEn || mulEn || cdb.valid, 2) || $past(mulLaunch.start))
    else begin
        $error("multiplier start without an earlier issue or CDB");
        failCount++;
    end

    stallNeedsEnable: assert property (@(posedge clk) disable iff (reset)
        !(addEn || mulEn) |-> !stall)
    else begin
        $error("stall high with no enable");
        failCount++;
    end

    // single-cycle write pulse
    writeOneCycle: assert property (@(posedge clk) disable iff (reset)
        regWrite.valid |=> !regWrite.valid)
    else begin
        $error("regWrite valid held longer than one cycle");
        failCount++;
    end

endmodule

bind reservationStation rsAsserts checks (
    .clk(clk),
    .reset(reset),
    .addEn(addEn),
    .mulEn(mulEn),
    .stall(stall),
    .cdb(cdb),
    .addLaunch(addLaunch),
    .mulLaunch(mulLaunch),
    .regWrite(regWrite)
);

`default_nettype wire

// ==== rs_tests.txt ====
# kind rs rt rd imm immVal cdbTag cdbData cycles expTag expA expB (all hex)
# kind 0 add, 1 mul, 2 cdb with write to rd, 3 cdb without write, 4 add that must stall
0 02 03 01 0 00000000 0 00000000 2 1 11110202 11110303
0 05 00 04 1 00000abc 0 00000000 2 2 11110505 00000abc
1 01 07 06 0 00000000 0 00000000 0 4 00000000 00000000
2 00 00 01 0 00000000 1 deadbeef 2 4 deadbeef 11110707
0 09 0a 08 0 00000000 0 00000000 2 1 11110909 11110a0a
0 0b 0c 08 0 00000000 0 00000000 2 3 11110b0b 11110c0c
4 02 03 14 0 00000000 0 00000000 0 0 00000000 00000000
3 00 00 00 0 00000000 1 12345678 0 0 00000000 00000000
0 0d 0e 0f 0 00000000 0 00000000 2 1 11110d0d 11110e0e
1 04 08 10 0 00000000 2 a5a50002 0 5 00000000 00000000
2 00 00 08 0 00000000 3 cafe0003 2 5 a5a50002 cafe0003
2 00 00 06 0 00000000 4 0bad0004 0 0 00000000 00000000
1 12 00 11 1 00000007 0 00000000 2 4 11111212 00000007

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/1ns -f verilog.f \
    --top-module tb_reservationStation
out=$(./obj_dir/Vtb_reservationStation +verilator+error+limit+100 || true)
echo "$out"
echo "$out" | grep -qx "=== PASS ==="

// ==== stationBank.sv ====
`timescale 1ns/1ns
`default_nettype none

module stationBank #(
    parameter type opT = logic,
    parameter int depth = 2
) (
    input logic clk,
    input logic reset,
    input logic [depth-1:0] alloc,
    input tomasulo_pkg::newEntry_t entry,
    input logic [depth-1:0] fire,
    input tomasulo_pkg::cdb_t cdb,
    input tomasulo_pkg::tag_t baseTag,
    output logic [depth-1:0] free,
    output logic [depth-1:0] ready,
    output tomasulo_pkg::word_t srcA [depth],
    output tomasulo_pkg::word_t srcB [depth],
    output opT ops [depth],
    output tomasulo_pkg::tag_t tags [depth]
);

    logic [depth-1:0] busy;
    logic [depth-1:0] fired;
    logic [depth-1:0] done;
    tomasulo_pkg::operand_t opJ [depth];
    tomasulo_pkg::operand_t opK [depth];
    opT opStore [depth];

    // true when a waiting operand sees its producer on the cdb
    function automatic logic catches(
        input tomasulo_pkg::tag_t q,
        input tomasulo_pkg::cdb_t c
    );
        return q != '0 && c.valid && c.tag == q;
    endfunction

    for (genvar g = 0; g < depth; g++) begin : gEntry
        assign tags[g] = baseTag + tomasulo_pkg::tag_t'(g);
        // own result on the cdb frees the entry
        assign done[g] = busy[g] && cdb.valid && cdb.tag == tags[g];
        assign free[g] = !busy[g];
        assign ready[g] = busy[g] && !fired[g] && opJ[g].q == '0 && opK[g].q == '0;
        assign srcA[g] = opJ[g].v;
        assign srcB[g] = opK[g].v;
        assign ops[g] = opStore[g];
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            busy <= '0;
            fired <= '0;
        end else begin
            for (int i = 0; i < depth; i++) begin
                if (alloc[i]) begin
                    busy[i] <= 1'b1;
                    fired[i] <= 1'b0;
                end else if (done[i]) begin
                    busy[i] <= 1'b0;
                    fired[i] <= 1'b0;
                end else if (fire[i]) begin
                    fired[i] <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < depth; i++) begin
            if (alloc[i]) begin
                opJ[i] <= entry.j;
                opK[i] <= entry.k;
                opStore[i] <= opT'(entry.op);
            end else begin
                if (catches(opJ[i].q, cdb)) begin
                    opJ[i].q <= '0;
                    opJ[i].v <= cdb.data;
                end
                if (catches(opK[i].q, cdb)) begin
                    opK[i].q <= '0;
                    opK[i].v <= cdb.data;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== tb_reservationStation.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "tomasulo_defs.svh"

module tb_reservationStation;

    logic clk;
    logic reset;
    tomasulo_pkg::regAddr_t rs;
    tomasulo_pkg::regAddr_t rt;
    tomasulo_pkg::regAddr_t rd;
    logic addEn;
    logic mulEn;
    logic opSel;
    logic immInstr;
    tomasulo_pkg::word_t extImm;
    tomasulo_pkg::word_t readData1;
    tomasulo_pkg::word_t readData2;
    tomasulo_pkg::cdb_t cdb;
    logic stall;
    tomasulo_pkg::launch_t addLaunch;
    tomasulo_pkg::launch_t mulLaunch;
    tomasulo_pkg::regWrite_t regWrite;
    tomasulo_pkg::regAddr_t readAddr1;
    tomasulo_pkg::regAddr_t readAddr2;

    tomasulo_pkg::word_t regFile [`REG_N];
    logic opByTag [16];
    int testErrors;
    int passed;
    int failed;
    int seed;

    reservationStation DUT (.*);

    // register file answers in the same cycle
    assign readData1 = regFile[readAddr1];
    assign readData2 = regFile[readAddr2];

    always #10 clk = ~clk;

    task automatic issueOp(input logic isMul, input logic [31:0] s, t, d, imm, immVal,
                           input logic [31:0] cTag, cData, eTag);
        int r;
        @(posedge clk);
        #2;
        r = $random(seed);
        rs = tomasulo_pkg::regAddr_t'(s);
        rt = tomasulo_pkg::regAddr_t'(t);
        rd = tomasulo_pkg::regAddr_t'(d);
        immInstr = imm[0];
        extImm = immVal;
        opSel = r[0];
        addEn = !isMul;
        mulEn = isMul;
        // optional broadcast in the issue cycle
        if (cTag != 0) begin
            cdb = '{valid: 1'b1, tag: tomasulo_pkg::tag_t'(cTag), data: cData};
        end
        opByTag[eTag[3:0]] = r[0];
        @(negedge clk);
        if (stall !== 1'b0) begin
            $display("Error at %0t: stall is %b at the issue of tag %0d, expected 0", $time,
                     stall, eTag);
            testErrors++;
        end
        if (readAddr1 !== tomasulo_pkg::regAddr_t'(s)
                || readAddr2 !== tomasulo_pkg::regAddr_t'(t)) begin
            $display("Error at %0t: read addresses %0d %0d, expected %0d %0d", $time,
                     readAddr1, readAddr2, s, t);
            testErrors++;
        end
        @(posedge clk);
        #2;
        addEn = 1'b0;
        mulEn = 1'b0;
        immInstr = 1'b0;
        cdb = '0;
    endtask

    task automatic holdStalled(input logic [31:0] s, t, d);
        @(posedge clk);
        #2;
        rs = tomasulo_pkg::regAddr_t'(s);
        rt = tomasulo_pkg::regAddr_t'(t);
        rd = tomasulo_pkg::regAddr_t'(d);
        addEn = 1'b1;
        @(negedge clk);
        if (stall !== 1'b1) begin
            $display("Error at %0t: stall is %b, expected 1", $time, stall);
            testErrors++;
        end
        @(posedge clk);
        #2;
        addEn = 1'b0;
    endtask

    task automatic broadcast(input logic [31:0] cTag, cData, input logic wantWrite,
                             input logic [31:0] d);
        @(posedge clk);
        #2;
        cdb = '{valid: 1'b1, tag: tomasulo_pkg::tag_t'(cTag), data: cData};
        @(posedge clk);
        #2;
        cdb = '0;
        // write-back shows one cycle after the broadcast edge
        @(negedge clk);
        if (regWrite.valid !== wantWrite) begin
            $display("Error at %0t: regWrite valid is %b, expected %b", $time,
                     regWrite.valid, wantWrite);
            testErrors++;
        end else if (wantWrite && (regWrite.addr !== tomasulo_pkg::regAddr_t'(d)
                                   || regWrite.data !== cData)) begin
            $display("Error at %0t: regWrite r%0d=%h, expected r%0d=%h", $time,
                     regWrite.addr, regWrite.data, d, cData);
            testErrors++;
        end
    endtask

    // count falling edges after the reference edge until start shows
    task automatic expectLaunch(input int firstCount, input logic [31:0] cycles,
                                input tomasulo_pkg::tag_t tag,
                                input tomasulo_pkg::word_t expA, expB);
        tomasulo_pkg::launch_t seen;
        int n;
        logic hit;
        n = firstCount;
        hit = 1'b0;
        while (!hit && n < firstCount + 12) begin
            @(negedge clk);
            n++;
            seen = (tag >= `MUL_BASE) ? mulLaunch : addLaunch;
            hit = seen.start;
        end
        if (!hit) begin
            $display("Timed out waiting for the launch of station %0d", tag);
            testErrors++;
        end else begin
            if (n != cycles) begin
                $display("Error at %0t: start after %0d cycles, expected %0d", $time, n, cycles);
                testErrors++;
            end
            if (seen.srcA !== expA || seen.srcB !== expB) begin
                $display("Error at %0t: srcA %h srcB %h, expected %h %h", $time,
                         seen.srcA, seen.srcB, expA, expB);
                testErrors++;
            end
            if (seen.tag !== tag || seen.op !== opByTag[tag]) begin
                $display("Error at %0t: tag %0d op %b, expected %0d %b", $time,
                         seen.tag, seen.op, tag, opByTag[tag]);
                testErrors++;
            end
        end
    endtask

    task automatic expectQuiet(input tomasulo_pkg::tag_t tag);
        tomasulo_pkg::launch_t seen;
        for (int n = 0; n < 4; n++) begin
            @(negedge clk);
            seen = (tag >= `MUL_BASE) ? mulLaunch : addLaunch;
            if (seen.start !== 1'b0) begin
                $display("Error at %0t: launch of tag %0d while operands pending", $time,
                         seen.tag);
                testErrors++;
            end
        end
    endtask

    initial begin
        logic [31:0] kind, s, t, d, imm, immVal, cTag, cData, cycles, eTag, eA, eB;
        string line;
        int fd;
        int got;
        int num;
        clk = 1'b0;
        reset = 1'b1;
        rs = '0;
        rt = '0;
        rd = '0;
        addEn = 1'b0;
        mulEn = 1'b0;
        opSel = 1'b0;
        immInstr = 1'b0;
        extImm = '0;
        cdb = '0;
        seed = 32'ha047_dcf8;
        passed = 0;
        failed = 0;
        num = 0;
        for (int i = 0; i < `REG_N; i++) begin
            regFile[i] = 32'h1111_0000 + i * 32'h0101;
        end
        for (int i = 0; i < 16; i++) begin
            opByTag[i] = 1'b0;
        end
        repeat (4) @(posedge clk);
        #2;
        reset = 1'b0;

        fd = $fopen("rs_tests.txt", "r");
        if (fd == 0) begin
            $display("Could not open rs_tests.txt");
            failed++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() < 2 || line[0] == "#") begin
                    continue;
                end
                got = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h", kind, s, t, d,
                              imm, immVal, cTag, cData, cycles, eTag, eA, eB);
                num++;
                testErrors = 0;
                if (got != 12) begin
                    $display("Test line %0d has %0d fields instead of 12", num, got);
                    testErrors++;
                end else begin
                    case (kind)
                        0, 1: begin
                            issueOp(kind == 1, s, t, d, imm, immVal, cTag, cData, eTag);
                            if (cycles != 0) begin
                                expectLaunch(0, cycles, eTag[3:0], eA, eB);
                            end else begin
                                expectQuiet(eTag[3:0]);
                            end
                        end
                        2, 3: begin
                            broadcast(cTag, cData, kind == 2, d);
                            if (cycles != 0) begin
                                expectLaunch(1, cycles, eTag[3:0], eA, eB);
                            end
                        end
                        4: holdStalled(s, t, d);
                        default: begin
                            $display("Test line %0d has an unknown kind %0d", num, kind);
                            testErrors++;
                        end
                    endcase
                end
                $display("test %0d kind %0d: %s", num, kind, testErrors == 0 ? "ok" : "failed");
                if (testErrors == 0) begin
                    passed++;
                end else begin
                    failed++;
                end
            end
            $fclose(fd);
        end

        $display("%0d tests, %0d passed, %0d failed, %0d assertion failures", num, passed,
                 failed, DUT.checks.failCount);
        if (failed == 0 && num > 0 && DUT.checks.failCount == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tomasulo_defs.svh ====
`ifndef TOMASULO_DEFS_SVH
`define TOMASULO_DEFS_SVH

// operand and tag widths
`define DATA_W 32
`define TAG_W 4

// architectural registers
`define REG_N 32

// stations per class
`define ADD_N 3
`define MUL_N 2

// first tag of each class
// tag 0 means value ready
`define ADD_BASE 1
`define MUL_BASE 4

`endif

// ==== tomasulo_pkg.sv ====
`default_nettype none
`include "tomasulo_defs.svh"

package tomasulo_pkg;

    typedef logic [`TAG_W-1:0] tag_t;
    typedef logic [`DATA_W-1:0] word_t;
    typedef logic [$clog2(`REG_N)-1:0] regAddr_t;

    typedef enum logic {
        ADD_OP = 1'b0,
        SUB_OP = 1'b1
    } addOp_t;

    // low or high half of the product
    typedef enum logic {
        MUL_LO = 1'b0,
        MUL_HI = 1'b1
    } mulOp_t;

    typedef struct packed {
        logic valid;
        tag_t tag;
        word_t data;
    } cdb_t;

    // q == 0 means v holds the value
    typedef struct packed {
        tag_t q;
        word_t v;
    } operand_t;

    typedef struct packed {
        operand_t j;
        operand_t k;
        logic op;
    } newEntry_t;

    typedef struct packed {
        logic start;
        word_t srcA;
        word_t srcB;
        tag_t tag;
        logic op;
    } launch_t;

    typedef struct packed {
        logic valid;
        regAddr_t addr;
        word_t data;
    } regWrite_t;

endpackage

`default_nettype wire

// ==== verilog.f ====
+incdir+.
tomasulo_pkg.sv
issueStage.sv
stationBank.sv
launchStage.sv
reservationStation.sv
rs_asserts.sv
tb_reservationStation.sv
